// ==== common/cp0_cfg.svh ====
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

`define CP0_EXC_VECTOR   32'hBFC00380            // general exception entry, BEV=1

`define CP0_STATUS_BEV   22                      // boot exception vectors
`define CP0_STATUS_IM_HI 15                      // interrupt mask, 8 bits
`define CP0_STATUS_IM_LO 8
`define CP0_STATUS_EXL   1                       // exception level
`define CP0_STATUS_IE    0                       // global interrupt enable
`define CP0_STATUS_RESET (32'h1 << `CP0_STATUS_BEV)
`define CP0_STATUS_WMASK 32'h0000_FF03           // IM, EXL, IE

`define CP0_CAUSE_BD     31                      // fault in delay slot
`define CP0_CAUSE_TI     30                      // timer pending
`define CP0_CAUSE_IP_HI  15                      // pending lines, 8 bits
`define CP0_CAUSE_IP_LO  8
`define CP0_CAUSE_EXC_HI 6                       // ExcCode field
`define CP0_CAUSE_EXC_LO 2
`define CP0_CAUSE_WMASK  32'h0000_0300           // software IP[1:0] only

`define CP0_COUNT_DIV    2                       // cycles per Count step

`endif

// ==== common/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // ExcCode field values, MIPS32 numbering
    typedef enum logic [4:0] {
        exc_int  = 5'd0,    // interrupt
        exc_adel = 5'd4,    // address error, load or fetch
        exc_ades = 5'd5,    // address error, store
        exc_sys  = 5'd8,    // syscall
        exc_bp   = 5'd9,    // break
        exc_ri   = 5'd10,   // reserved instruction
        exc_ov   = 5'd12    // arithmetic overflow
    } exc_code_t;

    // cp0 register numbers (rd field of mfc0/mtc0), sel 0 only
    typedef enum logic [4:0] {
        reg_badvaddr = 5'd8,    // last faulting address, read only
        reg_count    = 5'd9,    // free running timer
        reg_compare  = 5'd11,   // timer match value
        reg_status   = 5'd12,   // IM, EXL, IE, BEV
        reg_cause    = 5'd13,   // BD, TI, IP, ExcCode
        reg_epc      = 5'd14    // restart pc
    } cp0_reg_t;

endpackage

`default_nettype wire

// ==== cp0/exception_unit.sv ====
`include "cp0_cfg.svh"
`default_nettype none

module exception_unit (
    // commit stage strobes
    input  wire logic               valid,          // an instruction retires now
    input  wire logic [31:0]        pc,             // its pc
    input  wire logic               is_ds,          // sits in a branch delay slot
    input  wire logic               mem_we,         // store when addr_err is set
    input  wire logic               addr_err,       // data address misaligned
    input  wire logic [31:0]        err_addr,       // faulting data address
    input  wire logic               ovf,            // signed add/sub overflow
    input  wire logic               syscall,
    input  wire logic               brk,
    input  wire logic               reserved,       // decode saw no valid opcode
    input  wire logic               eret,
    // from the register file
    input  wire logic               int_pending,    // enabled and unmasked IP bit
    input  wire logic [31:0]        epc,            // current EPC, eret target
    // to the register file
    output logic                    exc_taken,
    output cp0_pkg::exc_code_t      exc_code,
    output logic [31:0]             exc_epc,
    output logic                    exc_bd,
    output logic [31:0]             exc_badvaddr,
    output logic                    badvaddr_we,
    output logic                    eret_taken,
    // to the pipeline
    output logic                    flush,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc
);

    // per-source requests, all qualified by valid
    logic src_int;      // async interrupt, taken on the retiring instr
    logic src_fetch;    // misaligned pc
    logic src_ri;
    logic src_ov;
    logic src_sys;
    logic src_bp;
    logic src_data;     // load/store alignment fault
    logic any_exc;      // one or more of the above

    assign src_int   = valid & int_pending;
    assign src_fetch = valid & (pc[1:0] != 2'b00);     // word aligned fetch only
    assign src_ri    = valid & reserved;
    assign src_ov    = valid & ovf;
    assign src_sys   = valid & syscall;
    assign src_bp    = valid & brk;
    assign src_data  = valid & addr_err;

    assign any_exc = src_int | src_fetch | src_ri | src_ov |
                     src_sys | src_bp | src_data;

    // fixed priority, first match wins
    always_comb begin
        exc_code     = cp0_pkg::exc_int;    // don't care unless any_exc
        exc_badvaddr = 32'h0;
        badvaddr_we  = 1'b0;
        if (src_int) begin
            exc_code = cp0_pkg::exc_int;    // interrupt beats everything
        end else if (src_fetch) begin
            exc_code     = cp0_pkg::exc_adel;   // fetch faults report as load
            exc_badvaddr = pc;
            badvaddr_we  = 1'b1;
        end else if (src_ri) begin
            exc_code = cp0_pkg::exc_ri;
        end else if (src_ov) begin
            exc_code = cp0_pkg::exc_ov;
        end else if (src_sys) begin
            exc_code = cp0_pkg::exc_sys;
        end else if (src_bp) begin
            exc_code = cp0_pkg::exc_bp;
        end else if (src_data) begin
            if (mem_we) begin
                exc_code = cp0_pkg::exc_ades;   // store side
            end else begin
                exc_code = cp0_pkg::exc_adel;   // load side
            end
            exc_badvaddr = err_addr;
            badvaddr_we  = 1'b1;
        end
    end

    assign exc_taken = any_exc;

    // restart at the branch when the faulting instr is in its slot
    assign exc_epc = is_ds ? (pc - 32'd4) : pc;
    assign exc_bd  = is_ds;

    // eret never retires alongside an exception
    assign eret_taken = valid & eret & ~any_exc;

    // one flush per taken event, same cycle as commit
    assign flush          = exc_taken | eret_taken;
    assign redirect_valid = flush;

    // exception wins the target, else return to EPC
    always_comb begin
        if (exc_taken) begin
            redirect_pc = `CP0_EXC_VECTOR;
        end else begin
            redirect_pc = epc;      // only meaningful with eret_taken
        end
    end

endmodule

`default_nettype wire

// ==== cp0/cp0_regs.sv ====
`include "cp0_cfg.svh"
`default_nettype none

module cp0_regs (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [5:0]         hw_int,         // async level inputs
    // mtc0/mfc0 access
    input  wire logic               mtc0_we,
    input  wire cp0_pkg::cp0_reg_t  cp0_addr,       // shared by read and write
    input  wire logic [31:0]        wdata,
    // exception unit updates
    input  wire logic               exc_taken,
    input  wire cp0_pkg::exc_code_t exc_code,
    input  wire logic [31:0]        exc_epc,
    input  wire logic               exc_bd,
    input  wire logic [31:0]        exc_badvaddr,
    input  wire logic               badvaddr_we,
    input  wire logic               eret_taken,
    output logic [31:0]             rdata,          // mfc0 result, combinational
    output logic [31:0]             epc,
    output logic                    int_pending
);

    localparam int unsigned COUNT_DIV = `CP0_COUNT_DIV;
    localparam int unsigned DIV_W     = $clog2(COUNT_DIV + 1);     // at least one bit

    logic [31:0]        status_q;
    logic [31:0]        status_d;
    logic               exl;            // current exception level
    logic               cause_bd;
    logic               cause_ti;       // timer hit, held until Compare write
    logic [1:0]         cause_sw;       // software IP[1:0]
    cp0_pkg::exc_code_t cause_exc;
    logic [7:0]         cause_ip;       // assembled pending lines
    logic [31:0]        cause_word;
    logic [31:0]        cause_wr;       // masked mtc0 data for Cause
    logic [31:0]        badvaddr_q;
    logic [31:0]        count_q;
    logic [31:0]        compare_q;
    logic [DIV_W-1:0]   div_cnt;        // prescaler for Count
    logic               count_tick;     // Count steps this cycle
    logic               count_moved;    // Count stepped on the last edge
    logic [5:0]         hw_meta;        // first sync stage
    logic [5:0]         hw_sync;        // second sync stage
    logic               wr_status;
    logic               wr_cause;
    logic               wr_epc;
    logic               wr_count;
    logic               wr_compare;

    // mtc0 decode
    assign wr_status  = mtc0_we & (cp0_addr == cp0_pkg::reg_status);
    assign wr_cause   = mtc0_we & (cp0_addr == cp0_pkg::reg_cause);
    assign wr_epc     = mtc0_we & (cp0_addr == cp0_pkg::reg_epc);
    assign wr_count   = mtc0_we & (cp0_addr == cp0_pkg::reg_count);
    assign wr_compare = mtc0_we & (cp0_addr == cp0_pkg::reg_compare);

    assign cause_wr = wdata & `CP0_CAUSE_WMASK;
    assign exl      = status_q[`CP0_STATUS_EXL];

    // Status: masked write first, exception/eret override EXL
    always_comb begin
        status_d = status_q;
        if (wr_status) begin
            status_d = (status_q & ~`CP0_STATUS_WMASK) | (wdata & `CP0_STATUS_WMASK);
        end
        if (exc_taken) begin
            status_d[`CP0_STATUS_EXL] = 1'b1;
        end else if (eret_taken) begin
            status_d[`CP0_STATUS_EXL] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= `CP0_STATUS_RESET;
        end else begin
            status_q <= status_d;
        end
    end

    // Cause, EPC and BadVAddr
    always_ff @(posedge clk) begin
        if (rst) begin
            cause_sw   <= 2'b00;
            cause_bd   <= 1'b0;
            cause_exc  <= cp0_pkg::exc_int;
            epc        <= 32'h0;
            badvaddr_q <= 32'h0;
        end else begin
            if (wr_cause) begin
                cause_sw <= cause_wr[`CP0_CAUSE_IP_LO+1:`CP0_CAUSE_IP_LO];
            end
            if (exc_taken) begin
                cause_exc <= exc_code;
                if (!exl) begin
                    cause_bd <= exc_bd;     // nested fault keeps first BD
                end
            end
            if (exc_taken && !exl) begin
                epc <= exc_epc;             // beats a same-cycle mtc0
            end else if (wr_epc) begin
                epc <= wdata;
            end
            if (exc_taken && badvaddr_we) begin
                badvaddr_q <= exc_badvaddr;
            end
        end
    end

    // two-flop sync on the hardware lines
    always_ff @(posedge clk) begin
        if (rst) begin
            hw_meta <= 6'h0;
            hw_sync <= 6'h0;
        end else begin
            hw_meta <= hw_int;
            hw_sync <= hw_meta;
        end
    end

    assign count_tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt     <= '0;
            count_q     <= 32'h0;
            count_moved <= 1'b0;
        end else begin
            div_cnt     <= count_tick ? '0 : div_cnt + 1'b1;
            count_moved <= count_tick & ~wr_count;
            if (wr_count) begin
                count_q <= wdata;
            end else if (count_tick) begin
                count_q <= count_q + 32'd1;     // wraps
            end
        end
    end

    // timer fires the edge after Count lands on Compare
    always_ff @(posedge clk) begin
        if (rst) begin
            compare_q <= 32'h0;
            cause_ti  <= 1'b0;
        end else if (wr_compare) begin
            compare_q <= wdata;
            cause_ti  <= 1'b0;              // Compare write acks the timer
        end else if (count_moved && (count_q == compare_q)) begin
            cause_ti  <= 1'b1;
        end
    end

    // IP7 shared by hw line 5 and the timer
    assign cause_ip = {hw_sync[5] | cause_ti, hw_sync[4:0], cause_sw};

    always_comb begin
        cause_word                                      = 32'h0;
        cause_word[`CP0_CAUSE_BD]                       = cause_bd;
        cause_word[`CP0_CAUSE_TI]                       = cause_ti;
        cause_word[`CP0_CAUSE_IP_HI:`CP0_CAUSE_IP_LO]   = cause_ip;
        cause_word[`CP0_CAUSE_EXC_HI:`CP0_CAUSE_EXC_LO] = cause_exc;
    end

    assign int_pending = status_q[`CP0_STATUS_IE] & ~exl &
                         (|(cause_ip & status_q[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO]));

    // mfc0 read mux
    always_comb begin
        case (cp0_addr)
            cp0_pkg::reg_badvaddr: rdata = badvaddr_q;
            cp0_pkg::reg_count:    rdata = count_q;
            cp0_pkg::reg_compare:  rdata = compare_q;
            cp0_pkg::reg_status:   rdata = status_q;
            cp0_pkg::reg_cause:    rdata = cause_word;
            cp0_pkg::reg_epc:      rdata = epc;
            default:               rdata = 32'h0;   // unimplemented reads zero
        endcase
    end

endmodule

`default_nettype wire

// ==== design/cp0_top.sv ====
`default_nettype none

module cp0_top (
    input  wire logic               clk,
    input  wire logic               rst,
    // commit stage
    input  wire logic               valid,
    input  wire logic [31:0]        pc,
    input  wire logic               is_ds,
    input  wire logic               mem_we,
    input  wire logic               addr_err,
    input  wire logic [31:0]        err_addr,
    input  wire logic               ovf,
    input  wire logic               syscall,
    input  wire logic               brk,
    input  wire logic               reserved,
    input  wire logic               eret,
    // mtc0/mfc0
    input  wire logic               mtc0_we,
    input  wire cp0_pkg::cp0_reg_t  cp0_addr,
    input  wire logic [31:0]        wdata,
    input  wire logic [5:0]         hw_int,         // external interrupt lines
    output logic [31:0]             rdata,
    // pipeline control
    output logic                    flush,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc
);

    logic               int_pending;    // regs -> unit
    logic [31:0]        epc;            // eret target
    logic               exc_taken;
    cp0_pkg::exc_code_t exc_code;
    logic [31:0]        exc_epc;
    logic               exc_bd;
    logic [31:0]        exc_badvaddr;
    logic               badvaddr_we;
    logic               eret_taken;

    exception_unit exc_i (
        .valid          (valid),
        .pc             (pc),
        .is_ds          (is_ds),
        .mem_we         (mem_we),
        .addr_err       (addr_err),
        .err_addr       (err_addr),
        .ovf            (ovf),
        .syscall        (syscall),
        .brk            (brk),
        .reserved       (reserved),
        .eret           (eret),
        .int_pending    (int_pending),
        .epc            (epc),
        .exc_taken      (exc_taken),
        .exc_code       (exc_code),
        .exc_epc        (exc_epc),
        .exc_bd         (exc_bd),
        .exc_badvaddr   (exc_badvaddr),
        .badvaddr_we    (badvaddr_we),
        .eret_taken     (eret_taken),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    cp0_regs regs_i (
        .clk            (clk),
        .rst            (rst),
        .hw_int         (hw_int),
        .mtc0_we        (mtc0_we),
        .cp0_addr       (cp0_addr),
        .wdata          (wdata),
        .exc_taken      (exc_taken),
        .exc_code       (exc_code),
        .exc_epc        (exc_epc),
        .exc_bd         (exc_bd),
        .exc_badvaddr   (exc_badvaddr),
        .badvaddr_we    (badvaddr_we),
        .eret_taken     (eret_taken),
        .rdata          (rdata),
        .epc            (epc),
        .int_pending    (int_pending)
    );

endmodule

`default_nettype wire

// ==== verification/cp0_asserts.sv ====
`include "cp0_cfg.svh"
`default_nettype none

module cp0_asserts (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        valid,
    input wire logic        flush,
    input wire logic        redirect_valid,
    input wire logic        exc_taken,
    input wire logic [31:0] status          // live Status register
);

    // flush and redirect always move together
    a_flush_redirect: assert property (@(posedge clk) disable iff (rst)
        flush == redirect_valid)
        else $error("flush and redirect_valid differ");

    // nothing retires, nothing to flush
    a_flush_needs_valid: assert property (@(posedge clk) disable iff (rst)
        flush |-> valid)
        else $error("flush raised without valid");

    // exception level entered one edge after the exception
    a_exl_after_exc: assert property (@(posedge clk) disable iff (rst)
        exc_taken |=> status[`CP0_STATUS_EXL])
        else $error("EXL not set after exception");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> !redirect_valid)
        else $error("redirect_valid high during reset");

endmodule

bind cp0_top cp0_asserts asserts_i (
    .clk            (clk),
    .rst            (rst),
    .valid          (valid),
    .flush          (flush),
    .redirect_valid (redirect_valid),
    .exc_taken      (exc_taken),
    .status         (regs_i.status_q)
);

`default_nettype wire

// ==== verification/tb_cp0.sv ====
`include "cp0_cfg.svh"
`default_nettype none

module tb_cp0;

    localparam logic [6:0] F_MEMWE = 7'd1;     // flag bits for commit_instr
    localparam logic [6:0] F_AERR  = 7'd2;
    localparam logic [6:0] F_OVF   = 7'd4;
    localparam logic [6:0] F_SYS   = 7'd8;
    localparam logic [6:0] F_BRK   = 7'd16;
    localparam logic [6:0] F_RI    = 7'd32;
    localparam logic [6:0] F_ERET  = 7'd64;

    logic clk = 1'b0;
    logic rst;
    logic valid, is_ds, mem_we, addr_err, ovf, syscall, brk, reserved, eret;
    logic [31:0] pc, err_addr, wdata, rdata, redirect_pc;
    logic mtc0_we, flush, redirect_valid;
    cp0_pkg::cp0_reg_t cp0_addr;
    logic [5:0] hw_int;
    logic [31:0] word;
    logic [31:0] rpc;
    logic [31:0] first_epc;
    logic        fl;
    logic        rv;

    cp0_top dut_i (.*);

    always #10 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic step();
        @(posedge clk);
        #2;                                     // drive point after the edge
    endtask

    task automatic read_reg(input cp0_pkg::cp0_reg_t a, output logic [31:0] v);
        cp0_addr = a;
        #1;
        v = rdata;
    endtask

    task automatic check_code(input cp0_pkg::exc_code_t exp);
        logic [31:0] c;
        cp0_pkg::exc_code_t got;
        read_reg(cp0_pkg::reg_cause, c);
        got = cp0_pkg::exc_code_t'(c[`CP0_CAUSE_EXC_HI:`CP0_CAUSE_EXC_LO]);
        if (got !== exp)
            fail_now($sformatf("ExcCode got %0d expected %s", got, exp.name()));
    endtask

    task automatic commit_idle(input int n);
        repeat (n) step();
    endtask

    task automatic mtc0_write(input cp0_pkg::cp0_reg_t a, input logic [31:0] v);
        mtc0_we = 1'b1;
        cp0_addr = a;
        wdata = v;
        step();
        mtc0_we = 1'b0;
    endtask

    task automatic set_hw_int(input logic [5:0] v);
        hw_int = v;
    endtask

    // one retiring instruction for one cycle, returns flush, redirect valid and target
    task automatic commit_instr(input logic [31:0] pc_v, input logic ds_v,
                                input logic [6:0] f, input logic [31:0] ea,
                                output logic got_flush, output logic got_rv,
                                output logic [31:0] got_pc);
        valid = 1'b1;
        pc = pc_v;
        is_ds = ds_v;
        {eret, reserved, brk, syscall, ovf, addr_err, mem_we} = f;
        err_addr = ea;
        #1;
        got_flush = flush;
        got_rv = redirect_valid;
        got_pc = redirect_pc;
        step();
        valid = 1'b0;
        {eret, reserved, brk, syscall, ovf, addr_err, mem_we} = 7'd0;
        is_ds = 1'b0;
    endtask

    task automatic take_exc(input logic [31:0] pc_v, input logic ds_v, input logic [6:0] f,
                            input logic [31:0] ea, input cp0_pkg::exc_code_t exp);
        logic        f_got;
        logic        v_got;
        logic [31:0] r_got;
        logic [31:0] st;
        commit_instr(pc_v, ds_v, f, ea, f_got, v_got, r_got);
        check_bit("flush", f_got, 1'b1);
        check_bit("redirect_valid", v_got, 1'b1);
        check_word("redirect_pc", r_got, `CP0_EXC_VECTOR);
        check_code(exp);
        read_reg(cp0_pkg::reg_status, st);
        check_bit("EXL", st[`CP0_STATUS_EXL], 1'b1);
    endtask

    task automatic eret_return();
        logic [31:0] e, st, r_got;
        logic        f_got;
        logic        v_got;
        read_reg(cp0_pkg::reg_epc, e);
        commit_instr(32'h0000_1000, 1'b0, F_ERET, 32'h0, f_got, v_got, r_got);
        check_bit("eret flush", f_got, 1'b1);
        check_bit("eret redirect_valid", v_got, 1'b1);
        check_word("eret redirect_pc", r_got, e);
        read_reg(cp0_pkg::reg_status, st);
        check_bit("EXL after eret", st[`CP0_STATUS_EXL], 1'b0);
    endtask

    task automatic wait_int_taken(input logic [31:0] pc_v, input int max_cycles);
        int n;
        logic f_got;
        logic v_got;
        logic [31:0] r_got, e;
        f_got = 1'b0;
        n = 0;
        while (!f_got && n < max_cycles) begin
            commit_instr(pc_v, 1'b0, 7'd0, 32'h0, f_got, v_got, r_got);
            n++;
        end
        if (!f_got) begin
            $display("timeout while waiting for an interrupt to be taken");
            $display("Simulation failed");
            $fatal(1);
        end
        check_bit("int redirect_valid", v_got, 1'b1);
        check_word("int redirect_pc", r_got, `CP0_EXC_VECTOR);
        check_code(cp0_pkg::exc_int);
        read_reg(cp0_pkg::reg_epc, e);
        check_word("int EPC", e, pc_v);
    endtask

    task automatic test_reset();
        read_reg(cp0_pkg::reg_status, word);
        check_word("reset Status", word, `CP0_STATUS_RESET);
        read_reg(cp0_pkg::reg_cause, word);
        check_word("reset Cause", word, 32'h0);
        read_reg(cp0_pkg::reg_count, word);
        check_word("reset Count", word, 32'h0);
        read_reg(cp0_pkg::reg_compare, word);
        check_word("reset Compare", word, 32'h0);
        read_reg(cp0_pkg::reg_epc, word);
        check_word("reset EPC", word, 32'h0);
        read_reg(cp0_pkg::reg_badvaddr, word);
        check_word("reset BadVAddr", word, 32'h0);
        check_bit("reset flush", flush, 1'b0);
        check_bit("reset redirect_valid", redirect_valid, 1'b0);
    endtask

    task automatic test_single(input logic [6:0] f, input cp0_pkg::exc_code_t exp);
        logic [31:0] p, e, c;
        for (int d = 0; d < 2; d++) begin
            p = $urandom & 32'hFFFF_FFFC;       // aligned fetch
            take_exc(p, d[0], f, 32'h0, exp);
            read_reg(cp0_pkg::reg_epc, e);
            check_word("EPC", e, d ? p - 32'd4 : p);
            read_reg(cp0_pkg::reg_cause, c);
            check_bit("Cause.BD", c[`CP0_CAUSE_BD], d[0]);
            eret_return();
        end
    endtask

    initial begin
        void'($urandom(32'h89f1));
        rst = 1'b1;
        {valid, is_ds, mem_we, addr_err, ovf, syscall, brk, reserved, eret} = 9'd0;
        pc = 32'h0;
        err_addr = 32'h0;
        mtc0_we = 1'b0;
        cp0_addr = cp0_pkg::reg_status;
        wdata = 32'h0;
        hw_int = 6'h0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();

        test_single(F_SYS, cp0_pkg::exc_sys);
        test_single(F_BRK, cp0_pkg::exc_bp);
        test_single(F_RI, cp0_pkg::exc_ri);
        test_single(F_OVF, cp0_pkg::exc_ov);
        test_single(F_AERR, cp0_pkg::exc_adel);
        test_single(F_AERR | F_MEMWE, cp0_pkg::exc_ades);

        // priority among combined flags
        take_exc(32'h0000_2000, 1'b0, F_RI | F_OVF | F_SYS, 32'h0, cp0_pkg::exc_ri);
        eret_return();
        take_exc(32'h0000_2004, 1'b0, F_OVF | F_SYS | F_BRK, 32'h0, cp0_pkg::exc_ov);
        eret_return();
        rpc = ($urandom & 32'hFFFF_FFFC) | 32'h2;   // misaligned fetch
        take_exc(rpc, 1'b0, F_RI | F_AERR, 32'h0, cp0_pkg::exc_adel);
        read_reg(cp0_pkg::reg_badvaddr, word);
        check_word("BadVAddr fetch", word, rpc);
        eret_return();
        rpc = $urandom;
        take_exc(32'h0000_3000, 1'b0, F_AERR | F_MEMWE, rpc, cp0_pkg::exc_ades);
        read_reg(cp0_pkg::reg_badvaddr, word);
        check_word("BadVAddr store", word, rpc);
        eret_return();
        rpc = $urandom;
        take_exc(32'h0000_3004, 1'b0, F_AERR, rpc, cp0_pkg::exc_adel);
        read_reg(cp0_pkg::reg_badvaddr, word);
        check_word("BadVAddr load", word, rpc);
        eret_return();

        // nested exception keeps the first EPC
        first_epc = $urandom & 32'hFFFF_FFFC;
        take_exc(first_epc, 1'b0, F_SYS, 32'h0, cp0_pkg::exc_sys);
        take_exc(32'h0000_4000, 1'b0, F_BRK, 32'h0, cp0_pkg::exc_bp);
        read_reg(cp0_pkg::reg_epc, word);
        check_word("nested EPC", word, first_epc);
        eret_return();

        // eret suppressed by a same-cycle overflow
        take_exc(32'h0000_5000, 1'b0, F_ERET | F_OVF, 32'h0, cp0_pkg::exc_ov);
        eret_return();

        // software interrupt, IE off first
        mtc0_write(cp0_pkg::reg_cause, 32'h0000_0100);
        commit_instr(32'h0000_6000, 1'b0, 7'd0, 32'h0, fl, rv, rpc);
        check_bit("flush with IE clear", fl, 1'b0);
        check_bit("redirect_valid with IE clear", rv, 1'b0);
        mtc0_write(cp0_pkg::reg_status, 32'h0000_0200 | 32'h1);    // IE on, IP0 masked
        commit_instr(32'h0000_6000, 1'b0, 7'd0, 32'h0, fl, rv, rpc);
        check_bit("flush with IM clear", fl, 1'b0);
        check_bit("redirect_valid with IM clear", rv, 1'b0);
        mtc0_write(cp0_pkg::reg_status, 32'h0000_0100 | 32'h1);
        wait_int_taken(32'h0000_6004, 4);
        commit_instr(32'h0000_6008, 1'b0, 7'd0, 32'h0, fl, rv, rpc);
        check_bit("flush with EXL set", fl, 1'b0);
        check_bit("redirect_valid with EXL set", rv, 1'b0);
        mtc0_write(cp0_pkg::reg_cause, 32'h0);
        eret_return();
        mtc0_write(cp0_pkg::reg_status, 32'h0);

        // hardware line 2 lands on IP4 after the synchronizer
        mtc0_write(cp0_pkg::reg_status, 32'h0000_1001);
        set_hw_int(6'b000100);
        wait_int_taken(32'h0000_7000, 10);
        read_reg(cp0_pkg::reg_cause, word);
        check_bit("Cause.IP4", word[12], 1'b1);
        set_hw_int(6'h0);
        commit_idle(3);
        eret_return();
        mtc0_write(cp0_pkg::reg_status, 32'h0);

        // timer on IP7
        mtc0_write(cp0_pkg::reg_count, 32'h0);
        mtc0_write(cp0_pkg::reg_compare, 32'd12);
        mtc0_write(cp0_pkg::reg_status, 32'h0000_8001);
        wait_int_taken(32'h0000_8000, 200);
        read_reg(cp0_pkg::reg_cause, word);
        check_bit("Cause.IP7", word[15], 1'b1);
        mtc0_write(cp0_pkg::reg_compare, 32'hFFFF_0000);
        read_reg(cp0_pkg::reg_cause, word);
        check_bit("Cause.IP7 after Compare write", word[15], 1'b0);
        eret_return();
        mtc0_write(cp0_pkg::reg_status, 32'h0);

        commit_idle(2);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_cp0.f ====
+incdir+common
common/cp0_pkg.sv
cp0/exception_unit.sv
cp0/cp0_regs.sv
design/cp0_top.sv
verification/cp0_asserts.sv
verification/tb_cp0.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat mips_cp0.f))

.PHONY: all run clean

all: obj_dir/Vtb_cp0

obj_dir/Vtb_cp0: mips_cp0.f $(SRCS) common/cp0_cfg.svh
	verilator --binary --timing --assert -f mips_cp0.f --top-module tb_cp0 -Mdir obj_dir

run: obj_dir/Vtb_cp0
	./obj_dir/Vtb_cp0 | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
